// ==== conv_pkg.sv ====
package conv_pkg;

    // ======================================================================
    // Kernel geometry
    // ======================================================================

    // Side of the square kernel, fixed 3x3
    localparam int KERNEL_N = 3;

    // ======================================================================
    // Datapath widths
    // ======================================================================

    // Greyscale pixel, unsigned
    localparam int PIX_W = 8;

    // Kernel coefficient, two's complement
    localparam int COEF_W = 8;

    // One row dot product: zero-extended pixel times coefficient, three terms
    localparam int PROD_W = PIX_W + COEF_W + 2;

    // Sum of three row partials
    localparam int ACC_W = PROD_W + 2;

    // Fraction shift field
    localparam int SHIFT_W = 4;

    // ======================================================================
    // Wishbone register map
    // ======================================================================

    localparam int WB_ADR_W = 4;
    localparam int WB_DAT_W = 32;

    // Coefficients at 0..8, row-major, low COEF_W bits
    localparam int REG_COEF_BASE = 0;

    // Fraction shift, low SHIFT_W bits
    localparam int REG_SHIFT = 9;

    // Output pixel count, read only, 16 bits wrapping
    localparam int REG_OUT_COUNT = 10;

endpackage

// ==== conv_coeff_regs.sv ====
`timescale 1ns/1ps

module conv_coeff_regs (
    input  logic                                                       clk,
    input  logic                                                       rst_n,
    input  logic                                                       wb_cyc,
    input  logic                                                       wb_stb,
    input  logic                                                       wb_we,
    input  logic [conv_pkg::WB_ADR_W-1:0]                              wb_adr,
    input  logic [conv_pkg::WB_DAT_W-1:0]                              wb_dat_w,
    output logic [conv_pkg::WB_DAT_W-1:0]                              wb_dat_r,
    output logic                                                       wb_ack,
    input  logic                                                       out_fire,
    output logic [conv_pkg::KERNEL_N*conv_pkg::KERNEL_N*conv_pkg::COEF_W-1:0] coef_flat,
    output logic [conv_pkg::SHIFT_W-1:0]                               frac_shift
);

    localparam int NUM_TAPS = conv_pkg::KERNEL_N * conv_pkg::KERNEL_N;
    localparam int CW       = conv_pkg::COEF_W;
    localparam int AW       = conv_pkg::WB_ADR_W;
    localparam int DW       = conv_pkg::WB_DAT_W;
    localparam int SW       = conv_pkg::SHIFT_W;

    // New request seen, ack not yet given
    logic        req;
    logic [CW-1:0] coef [NUM_TAPS];
    logic [15:0] out_count;

    assign req = wb_cyc & wb_stb & ~wb_ack;

    // ======================================================================
    // Bus handshake and register writes
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack     <= 1'b0;
            frac_shift <= '0;
            for (int i = 0; i < NUM_TAPS; i++) begin
                coef[i] <= '0;
            end
        end else begin
            // Single-cycle ack, dropped before the next request is seen
            wb_ack <= req;
            if (req && wb_we) begin
                for (int i = 0; i < NUM_TAPS; i++) begin
                    if (wb_adr == AW'(conv_pkg::REG_COEF_BASE + i)) begin
                        coef[i] <= wb_dat_w[CW-1:0];
                    end
                end
                if (wb_adr == AW'(conv_pkg::REG_SHIFT)) begin
                    frac_shift <= wb_dat_w[SW-1:0];
                end
                // Count register and unmapped words ignore writes
            end
        end
    end

    // Completed output transfers, free-running and wrapping
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_count <= '0;
        end else if (out_fire) begin
            out_count <= out_count + 16'd1;
        end
    end

    // Read mux, held stable by the host while ack is high
    always_comb begin
        wb_dat_r = '0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            if (wb_adr == AW'(conv_pkg::REG_COEF_BASE + i)) begin
                wb_dat_r = DW'(coef[i]);
            end
        end
        if (wb_adr == AW'(conv_pkg::REG_SHIFT)) begin
            wb_dat_r = DW'(frac_shift);
        end
        if (wb_adr == AW'(conv_pkg::REG_OUT_COUNT)) begin
            wb_dat_r = DW'(out_count);
        end
    end

    // Row-major packing, tap 0 in the low bits
    always_comb begin
        for (int i = 0; i < NUM_TAPS; i++) begin
            coef_flat[i*CW +: CW] = coef[i];
        end
    end

endmodule

// ==== conv_window_gen.sv ====
`timescale 1ns/1ps

module conv_window_gen #(
    parameter int IMG_WIDTH  = 320,
    parameter int IMG_HEIGHT = 240
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           x_valid,
    input  logic [conv_pkg::PIX_W-1:0]                     x_data,
    input  logic                                           adv,
    output logic [conv_pkg::KERNEL_N*conv_pkg::PIX_W-1:0]  win_row0,
    output logic [conv_pkg::KERNEL_N*conv_pkg::PIX_W-1:0]  win_row1,
    output logic [conv_pkg::KERNEL_N*conv_pkg::PIX_W-1:0]  win_row2,
    output logic                                           win_valid
);

    localparam int PW    = conv_pkg::PIX_W;
    localparam int KN    = conv_pkg::KERNEL_N;
    localparam int COL_W = $clog2(IMG_WIDTH);
    localparam int ROW_W = $clog2(IMG_HEIGHT);

    // Pixel taken this cycle, x_ready is adv
    logic          accept;
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    // Enough lines and columns behind this pixel for a full window
    logic          interior;

    // Line memories, indexed by column
    logic [PW-1:0] line_a [IMG_WIDTH];
    logic [PW-1:0] line_b [IMG_WIDTH];
    // Same-column pixel one and two lines up
    logic [PW-1:0] tap_a;
    logic [PW-1:0] tap_b;

    assign accept   = x_valid & adv;
    assign interior = (col >= COL_W'(KN - 1)) && (row >= ROW_W'(KN - 1));
    assign tap_a    = line_a[col];
    assign tap_b    = line_b[col];

    // ======================================================================
    // Raster position
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (accept) begin
            if (col == COL_W'(IMG_WIDTH - 1)) begin
                col <= '0;
                // Wrap to the next frame after the last line
                if (row == ROW_W'(IMG_HEIGHT - 1)) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // ======================================================================
    // Line buffers and window register
    // ======================================================================

    // Column moves down one line per accepted pixel
    always_ff @(posedge clk) begin
        if (accept) begin
            line_b[col] <= tap_a;
            line_a[col] <= x_data;
        end
    end

    // New column enters at the top bits, column 0 holds the oldest pixel
    always_ff @(posedge clk) begin
        if (accept) begin
            win_row0 <= {tap_b, win_row0[KN*PW-1:PW]};
            win_row1 <= {tap_a, win_row1[KN*PW-1:PW]};
            win_row2 <= {x_data, win_row2[KN*PW-1:PW]};
        end
    end

    // Tag loads every adv edge so an idle input becomes a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else if (adv) begin
            win_valid <= accept & interior;
        end
    end

endmodule

// ==== conv_row_mac.sv ====
`timescale 1ns/1ps

module conv_row_mac (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            adv,
    input  logic                                            in_valid,
    input  logic [conv_pkg::KERNEL_N*conv_pkg::PIX_W-1:0]   pix_row,
    input  logic [conv_pkg::KERNEL_N*conv_pkg::COEF_W-1:0]  coef_row,
    output logic signed [conv_pkg::PROD_W-1:0]              part_sum,
    output logic                                            part_valid
);

    localparam int PW  = conv_pkg::PIX_W;
    localparam int CW  = conv_pkg::COEF_W;
    localparam int KN  = conv_pkg::KERNEL_N;
    localparam int PRW = conv_pkg::PROD_W;

    logic signed [PRW-1:0] pix_ext [KN];
    logic signed [PRW-1:0] coef_ext [KN];
    logic signed [PRW-1:0] dot;

    // Pixels unsigned, coefficients signed, all widened before the multiply
    always_comb begin
        dot = '0;
        for (int i = 0; i < KN; i++) begin
            pix_ext[i]  = PRW'(pix_row[i*PW +: PW]);
            coef_ext[i] = PRW'(signed'(coef_row[i*CW +: CW]));
            dot         = dot + pix_ext[i] * coef_ext[i];
        end
    end

    // Partial sum register
    always_ff @(posedge clk) begin
        if (adv) begin
            part_sum <= dot;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            part_valid <= 1'b0;
        end else if (adv) begin
            part_valid <= in_valid;
        end
    end

endmodule

// ==== conv_sum_out.sv ====
`timescale 1ns/1ps

module conv_sum_out (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic signed [conv_pkg::PROD_W-1:0] part_sum0,
    input  logic signed [conv_pkg::PROD_W-1:0] part_sum1,
    input  logic signed [conv_pkg::PROD_W-1:0] part_sum2,
    input  logic                               part_valid,
    input  logic [conv_pkg::SHIFT_W-1:0]       frac_shift,
    input  logic                               y_ready,
    output logic                               y_valid,
    output logic [conv_pkg::PIX_W-1:0]         y_data,
    output logic                               adv,
    output logic                               out_fire
);

    localparam int PW = conv_pkg::PIX_W;
    localparam int AW = conv_pkg::ACC_W;

    // Full window sum, sign-extended partials
    logic signed [AW-1:0] acc;
    // After the fraction shift
    logic signed [AW-1:0] scaled;

    // ======================================================================
    // Sum and scale
    // ======================================================================

    assign acc    = AW'(part_sum0) + AW'(part_sum1) + AW'(part_sum2);
    assign scaled = acc >>> frac_shift;

    // ======================================================================
    // Output register and flow control
    // ======================================================================

    // Whole pipeline moves when this slot is free or being drained
    assign adv      = ~y_valid | y_ready;
    assign out_fire = y_valid & y_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y_valid <= 1'b0;
        end else if (adv) begin
            y_valid <= part_valid;
        end
    end

    // Low pixel bits only, result wraps
    always_ff @(posedge clk) begin
        if (adv) begin
            y_data <= scaled[PW-1:0];
        end
    end

endmodule

// ==== conv_filter_top.sv ====
`timescale 1ns/1ps

module conv_filter_top #(
    parameter int IMG_WIDTH  = 320,
    parameter int IMG_HEIGHT = 240
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // Pixel input stream
    input  logic                          x_valid,
    output logic                          x_ready,
    input  logic [conv_pkg::PIX_W-1:0]    x_data,
    // Pixel output stream
    output logic                          y_valid,
    input  logic                          y_ready,
    output logic [conv_pkg::PIX_W-1:0]    y_data,
    // Wishbone classic slave
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [conv_pkg::WB_ADR_W-1:0] wb_adr,
    input  logic [conv_pkg::WB_DAT_W-1:0] wb_dat_w,
    output logic [conv_pkg::WB_DAT_W-1:0] wb_dat_r,
    output logic                          wb_ack
);

    localparam int KN  = conv_pkg::KERNEL_N;
    localparam int PW  = conv_pkg::PIX_W;
    localparam int CW  = conv_pkg::COEF_W;
    localparam int PRW = conv_pkg::PROD_W;

    // Shared stage enable from the output register
    logic                  adv;
    logic                  out_fire;
    logic [KN*KN*CW-1:0]   coef_flat;
    logic [conv_pkg::SHIFT_W-1:0] frac_shift;

    logic [KN*PW-1:0]      win_rows [KN];
    logic                  win_valid;
    logic signed [PRW-1:0] part_sums [KN];
    // Identical tags, unit 0 drives the output stage
    logic [KN-1:0]         row_valid;

    assign x_ready = adv;

    conv_coeff_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .out_fire   (out_fire),
        .coef_flat  (coef_flat),
        .frac_shift (frac_shift)
    );

    conv_window_gen #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) u_window (
        .clk       (clk),
        .rst_n     (rst_n),
        .x_valid   (x_valid),
        .x_data    (x_data),
        .adv       (adv),
        .win_row0  (win_rows[0]),
        .win_row1  (win_rows[1]),
        .win_row2  (win_rows[2]),
        .win_valid (win_valid)
    );

    // One MAC per kernel row, coefficient row r sliced from the flat word
    for (genvar r = 0; r < KN; r++) begin : g_row
        conv_row_mac u_mac (
            .clk        (clk),
            .rst_n      (rst_n),
            .adv        (adv),
            .in_valid   (win_valid),
            .pix_row    (win_rows[r]),
            .coef_row   (coef_flat[r*KN*CW +: KN*CW]),
            .part_sum   (part_sums[r]),
            .part_valid (row_valid[r])
        );
    end

    conv_sum_out u_out (
        .clk        (clk),
        .rst_n      (rst_n),
        .part_sum0  (part_sums[0]),
        .part_sum1  (part_sums[1]),
        .part_sum2  (part_sums[2]),
        .part_valid (row_valid[0]),
        .frac_shift (frac_shift),
        .y_ready    (y_ready),
        .y_valid    (y_valid),
        .y_data     (y_data),
        .adv        (adv),
        .out_fire   (out_fire)
    );

endmodule

// ==== tb_conv_filter.sv ====
`timescale 1ns/1ps

module tb_conv_filter;

    localparam int IMG_W        = 8;
    localparam int IMG_H        = 6;
    localparam int FRAME_PIX    = IMG_W * IMG_H;
    localparam int NUM_TESTS    = 5;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * FRAME_PIX * 8 + RESET_CYCLES;
    localparam int PAT_RAMP     = 0;
    localparam int PAT_CONST    = 1;
    localparam int PAT_RANDOM   = 2;

    logic        clk;
    logic        rst_n;
    logic        x_valid;
    logic        x_ready;
    logic [7:0]  x_data;
    logic        y_valid;
    logic        y_ready;
    logic [7:0]  y_data;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    // Stimulus table with one entry per frame
    string tbl_name    [NUM_TESTS];
    int    tbl_coef    [NUM_TESTS][9];
    int    tbl_shift   [NUM_TESTS];
    int    tbl_pattern [NUM_TESTS];
    bit    tbl_stall   [NUM_TESTS];

    int         frame_pix [IMG_H][IMG_W];
    logic [7:0] exp_q [$];
    logic [7:0] got_q [$];
    int         err_count;
    int         failed_tests;
    int         total_outputs;

    conv_filter_top #(
        .IMG_WIDTH  (IMG_W),
        .IMG_HEIGHT (IMG_H)
    ) dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .x_valid  (x_valid),
        .x_ready  (x_ready),
        .x_data   (x_data),
        .y_valid  (y_valid),
        .y_ready  (y_ready),
        .y_data   (y_data),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Ends a run that stops making progress
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ======================================================================
    // Checking and reference model
    // ======================================================================

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            err_count++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    // Window sum of each interior pixel in raster order then shift and wrap to 8 bits
    function automatic void build_expected(input int t);
        int acc;
        exp_q.delete();
        for (int r = 2; r < IMG_H; r++) begin
            for (int c = 2; c < IMG_W; c++) begin
                acc = 0;
                for (int i = 0; i < 3; i++) begin
                    for (int j = 0; j < 3; j++) begin
                        acc += tbl_coef[t][i*3 + j] * frame_pix[r-2+i][c-2+j];
                    end
                end
                exp_q.push_back(8'((acc >>> tbl_shift[t]) & 255));
            end
        end
    endfunction

    function automatic void fill_frame(input int pattern);
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                if (pattern == PAT_RAMP) begin
                    frame_pix[r][c] = ((r * IMG_W + c) * 7) % 256;
                end else if (pattern == PAT_CONST) begin
                    frame_pix[r][c] = 8'hA5;
                end else begin
                    frame_pix[r][c] = int'($urandom % 256);
                end
            end
        end
    endfunction

    // ======================================================================
    // Bus and stream drivers
    // ======================================================================

    // One classic cycle with read data taken while ack is high
    task automatic wb_access(input logic we, input int adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= 4'(adr);
        wb_dat_w <= wdata;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        rdata = wb_dat_r;
        // Request drops on the ack edge
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input int adr, input logic [31:0] data);
        logic [31:0] rd_ignored;
        wb_access(1'b1, adr, data, rd_ignored);
    endtask

    task automatic wb_read(input int adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'h0, data);
    endtask

    // x_ready is stable at the falling edge and the next rising edge takes the pixel
    task automatic stream_frame();
        @(posedge clk);
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                x_valid <= 1'b1;
                x_data  <= 8'(frame_pix[r][c]);
                @(negedge clk);
                while (!x_ready) @(negedge clk);
                @(posedge clk);
            end
        end
        x_valid <= 1'b0;
    endtask

    task automatic drain_frame(input bit stall, input int n);
        while (got_q.size() < n) begin
            @(posedge clk);
            if (stall) begin
                y_ready <= ($urandom % 3) != 0;
            end else begin
                y_ready <= 1'b1;
            end
            @(negedge clk);
            if (y_valid && y_ready) begin
                got_q.push_back(y_data);
            end
        end
    endtask

    // ======================================================================
    // Tests
    // ======================================================================

    task automatic register_test();
        int          errs_before;
        int          vals [9];
        logic [31:0] rd;
        errs_before = err_count;
        vals = '{3, -7, 127, -128, 0, 1, -1, 64, -33};
        for (int k = 0; k < 9; k++) begin
            wb_write(conv_pkg::REG_COEF_BASE + k, 32'(vals[k]));
        end
        wb_write(conv_pkg::REG_SHIFT, 32'hFFFF_FFFB);
        // Read-only and unmapped words keep their contents
        wb_write(conv_pkg::REG_OUT_COUNT, 32'h0000_1234);
        wb_write(15, 32'hDEAD_BEEF);
        for (int k = 0; k < 9; k++) begin
            wb_read(conv_pkg::REG_COEF_BASE + k, rd);
            check_value($sformatf("coef[%0d]", k), rd, 32'(vals[k] & 255));
        end
        wb_read(conv_pkg::REG_SHIFT, rd);
        check_value("frac_shift", rd, 32'h0000_000B);
        wb_read(conv_pkg::REG_OUT_COUNT, rd);
        check_value("out_count", rd, 32'h0);
        wb_read(15, rd);
        check_value("unused word", rd, 32'h0);
        if (err_count != errs_before) failed_tests++;
        $display("test registers: %0d mismatches, %s", err_count - errs_before,
                 (err_count == errs_before) ? "ok" : "failed");
    endtask

    task automatic run_test(input int t);
        int errs_before;
        int extra;
        errs_before = err_count;
        extra = 0;
        for (int k = 0; k < 9; k++) begin
            wb_write(conv_pkg::REG_COEF_BASE + k, 32'(tbl_coef[t][k]));
        end
        wb_write(conv_pkg::REG_SHIFT, 32'(tbl_shift[t]));
        fill_frame(tbl_pattern[t]);
        build_expected(t);
        got_q.delete();
        fork
            stream_frame();
            drain_frame(tbl_stall[t], exp_q.size());
        join
        // Anything left in the pipeline now would be a duplicate
        @(posedge clk);
        y_ready <= 1'b1;
        repeat (6) begin
            @(negedge clk);
            if (y_valid) extra++;
        end
        check_value("extra y_valid", 32'(extra), 32'h0);
        // One output per pixel with both column and row at least 2
        check_value("output count", 32'(got_q.size() + extra),
                    32'((IMG_W - 2) * (IMG_H - 2)));
        for (int i = 0; i < got_q.size(); i++) begin
            check_value($sformatf("y_data[%0d]", i), 32'(got_q[i]), 32'(exp_q[i]));
        end
        total_outputs += got_q.size() + extra;
        if (err_count != errs_before) failed_tests++;
        $display("test %s: %0d outputs, %0d mismatches, %s", tbl_name[t], got_q.size(),
                 err_count - errs_before, (err_count == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        logic [31:0] rd;
        tbl_name    = '{"identity_ramp", "laplacian_random", "box_const",
                        "sobel_stall", "extreme_stall"};
        tbl_coef    = '{'{   0,    0,    0,    0,    1,    0,    0,    0,    0},
                        '{  -1,   -1,   -1,   -1,    8,   -1,   -1,   -1,   -1},
                        '{   1,    1,    1,    1,    1,    1,    1,    1,    1},
                        '{   1,    2,    1,    0,    0,    0,   -1,   -2,   -1},
                        '{ 127, -128,  127, -128,  127, -128,  127, -128,  127}};
        tbl_shift   = '{0, 0, 3, 1, 4};
        tbl_pattern = '{PAT_RAMP, PAT_RANDOM, PAT_CONST, PAT_RANDOM, PAT_RANDOM};
        tbl_stall   = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
        err_count     = 0;
        failed_tests  = 0;
        total_outputs = 0;
        void'($urandom(32'h43b4_c896));

        rst_n    <= 1'b0;
        x_valid  <= 1'b0;
        x_data   <= 8'h0;
        y_ready  <= 1'b1;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= 4'h0;
        wb_dat_w <= 32'h0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        register_test();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        // Counter wraps at 16 bits
        wb_read(conv_pkg::REG_OUT_COUNT, rd);
        check_value("REG_OUT_COUNT", rd, 32'(total_outputs % 65536));

        $display("tests run %0d, tests failed %0d, errors %0d",
                 NUM_TESTS + 1, failed_tests, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== conv_filter_top.f ====
conv_pkg.sv
conv_coeff_regs.sv
conv_window_gen.sv
conv_row_mac.sv
conv_sum_out.sv
conv_filter_top.sv
tb_conv_filter.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_conv_filter \
    -f conv_filter_top.f -o tb_conv_filter || exit 1
sim_out=$(./obj_dir/tb_conv_filter)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "Simulation finished: PASS" && exit 0 || exit 1
